// File: common/mux_defs.svh
`ifndef MUX_DEFS_SVH
`define MUX_DEFS_SVH

// Number of input beat streams; must be a power of two.
`define MUX_NB_IN 4

// Width of one data beat in bits.
`define MUX_DWIDTH 32

// Depth of the queue that holds pending order entries.
`define MUX_ORDER_DEPTH 16

// Depth of the output buffer.
`define MUX_OUT_DEPTH 32

// Output occupancy above which no further input beats are granted.
// Leaves room for the beats still travelling through the delay pipeline.
`define MUX_ALMOST_FULL 16

`endif

// File: common/mux_pkg.sv
`include "mux_defs.svh"

package mux_pkg;

    // Index of one input stream, as carried by the order stream.
    typedef logic [$clog2(`MUX_NB_IN)-1:0] stream_id_t;

    // One data beat.
    typedef logic [`MUX_DWIDTH-1:0] beat_data_t;

    // FIFO fill level, wide enough for a depth of 32.
    typedef logic [5:0] occup_t;

    // Running count of order entries.
    typedef logic [31:0] count_t;

    // One stage of the beat delay line, also the output FIFO write port.
    typedef struct packed {
        logic       valid;
        beat_data_t data;
    } beat_stage_t;

    // Sequencer state.
    typedef enum logic {
        SEL_IDLE,   // no stream selected
        SEL_WAIT    // stream selected, waiting for its beat
    } sel_state_t;

endpackage

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

// Circular buffer with valid/ready on both sides.
// The read side is a register that always holds the head entry.
module stream_fifo
    import mux_pkg::*;
#(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_valid,
    output logic             wr_ready,
    input  logic [WIDTH-1:0] wr_data,
    output logic             rd_valid,
    input  logic             rd_ready,
    output logic [WIDTH-1:0] rd_data,
    output occup_t           occupancy
);

    localparam int ptr_bits = $clog2(DEPTH);

    // Pointers wrap on their own only for a power-of-two depth.
    if ((1 << ptr_bits) != DEPTH) begin : g_depth_pow2
        $error("stream_fifo: DEPTH must be a power of two");
    end

    if (DEPTH >= (1 << $bits(occup_t))) begin : g_depth_fits
        $error("stream_fifo: DEPTH does not fit in occup_t");
    end

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] rd_ptr_nxt;
    logic                push;
    logic                pop;

    assign wr_ready   = occupancy != occup_t'(DEPTH);
    assign rd_valid   = occupancy != '0;
    assign push       = wr_valid && wr_ready;
    assign pop        = rd_valid && rd_ready;
    assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr_nxt;
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head register.
    // When the FIFO runs empty and is written in the same cycle, the new word
    // goes straight into the head register.
    always_ff @(posedge clk) begin
        if (push && (wr_ptr == rd_ptr_nxt)) begin
            rd_data <= wr_data;
        end else begin
            rd_data <= mem[rd_ptr_nxt];
        end
    end

endmodule

// File: ordered_mux/order_sequencer.sv
`timescale 1ns/1ps
`include "mux_defs.svh"

// Takes stream ids from the order queue one at a time and grants the named
// input stream. Granted beats go through a three-register delay line into
// the output FIFO.
module order_sequencer
    import mux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Order queue side.
    input  logic                  q_valid,
    input  stream_id_t            q_id,
    output logic                  q_ready,

    // Input beat streams.
    input  logic [`MUX_NB_IN-1:0] in_valid,
    input  beat_data_t            in_data [`MUX_NB_IN],
    output logic [`MUX_NB_IN-1:0] in_ready,

    // Output FIFO side.
    input  occup_t                out_occupancy,
    output beat_stage_t           wr_stage
);

    sel_state_t  state;
    stream_id_t  sel_id;
    logic        almost_full;
    logic        grant;
    logic        beat_xfer;
    logic        q_pop;
    beat_stage_t capture_stage;
    beat_stage_t delay_stage;

    // Up to three beats can still be in flight when this rises.
    assign almost_full = out_occupancy > occup_t'(`MUX_ALMOST_FULL);

    assign grant = (state == SEL_WAIT) && !almost_full;

    // Only the selected stream ever sees ready.
    always_comb begin
        in_ready = '0;
        if (grant) begin
            in_ready[sel_id] = 1'b1;
        end
    end

    assign beat_xfer = grant && in_valid[sel_id];

    // Next order entry is taken while idle, or together with the last beat.
    assign q_ready = (state == SEL_IDLE) || beat_xfer;
    assign q_pop   = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEL_IDLE;
        end else begin
            case (state)
                SEL_IDLE: begin
                    if (q_pop) begin
                        state <= SEL_WAIT;
                    end
                end
                SEL_WAIT: begin
                    // Back to back entries keep the state in SEL_WAIT.
                    if (beat_xfer && !q_pop) begin
                        state <= SEL_IDLE;
                    end
                end
                default: begin
                    state <= SEL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            sel_id <= q_id;
        end
    end

    // Delay line: capture, delay, write.
    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            capture_stage.data <= in_data[sel_id];
        end
        delay_stage.data <= capture_stage.data;
        wr_stage.data    <= delay_stage.data;

        if (rst) begin
            capture_stage.valid <= 1'b0;
            delay_stage.valid   <= 1'b0;
            wr_stage.valid      <= 1'b0;
        end else begin
            capture_stage.valid <= beat_xfer;
            delay_stage.valid   <= capture_stage.valid;
            wr_stage.valid      <= delay_stage.valid;
        end
    end

endmodule

// File: ordered_mux/ordered_mux.sv
`timescale 1ns/1ps
`include "mux_defs.svh"

// Ordered stream multiplexer.
// An order stream names, entry by entry, the input stream that supplies the
// next output beat. Orders are queued, beats are buffered at the output.
module ordered_mux
    import mux_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Order stream.
    input  logic                  order_valid,
    output logic                  order_ready,
    input  stream_id_t            order_data,

    // Input beat streams.
    input  logic [`MUX_NB_IN-1:0] in_valid,
    output logic [`MUX_NB_IN-1:0] in_ready,
    input  beat_data_t            in_data [`MUX_NB_IN],

    // Output beat stream.
    output logic                  out_valid,
    input  logic                  out_ready,
    output beat_data_t            out_data,

    // Order entries accepted and consumed.
    output count_t                in_ord_cnt,
    output count_t                out_ord_cnt
);

    // The stream id must cover every input exactly.
    if ((1 << $clog2(`MUX_NB_IN)) != `MUX_NB_IN) begin : g_nb_in_check
        $error("ordered_mux: MUX_NB_IN must be a power of two");
    end

    logic        q_valid;
    stream_id_t  q_id;
    logic        q_ready;
    beat_stage_t wr_stage;
    occup_t      out_occupancy;

    // Pending order entries.
    stream_fifo #(
        .WIDTH ($bits(stream_id_t)),
        .DEPTH (`MUX_ORDER_DEPTH)
    ) order_queue (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (order_valid),
        .wr_ready  (order_ready),
        .wr_data   (order_data),
        .rd_valid  (q_valid),
        .rd_ready  (q_ready),
        .rd_data   (q_id),
        .occupancy ()
    );

    order_sequencer sequencer (
        .clk           (clk),
        .rst           (rst),
        .q_valid       (q_valid),
        .q_id          (q_id),
        .q_ready       (q_ready),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_ready      (in_ready),
        .out_occupancy (out_occupancy),
        .wr_stage      (wr_stage)
    );

    // Grants stop at the almost-full level, so wr_ready is never low on a write.
    stream_fifo #(
        .WIDTH ($bits(beat_data_t)),
        .DEPTH (`MUX_OUT_DEPTH)
    ) out_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_stage.valid),
        .wr_ready  (),
        .wr_data   (wr_stage.data),
        .rd_valid  (out_valid),
        .rd_ready  (out_ready),
        .rd_data   (out_data),
        .occupancy (out_occupancy)
    );

    // Order counters.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ord_cnt  <= '0;
            out_ord_cnt <= '0;
        end else begin
            if (order_valid && order_ready) begin
                in_ord_cnt <= in_ord_cnt + 1'b1;
            end
            // An entry counts as consumed when the sequencer pops it.
            if (q_valid && q_ready) begin
                out_ord_cnt <= out_ord_cnt + 1'b1;
            end
        end
    end

endmodule

// File: bench/ordered_mux_assertions.sv
`timescale 1ns/1ps
`include "mux_defs.svh"

// Protocol checks on the ordered_mux ports.
module ordered_mux_assertions
    import mux_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [`MUX_NB_IN-1:0] in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input beat_data_t            out_data,
    input count_t                in_ord_cnt,
    input count_t                out_ord_cnt
);

    // One stream granted at a time.
    assert property (@(posedge clk) disable iff (rst) $onehot0(in_ready))
        else $error("in_ready has more than one bit set: %b", in_ready);

    // A stalled output beat stays put.
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data or out_valid changed while the sink stalled");

    assert property (@(posedge clk) disable iff (rst) out_ord_cnt <= in_ord_cnt)
        else $error("out_ord_cnt %0d is above in_ord_cnt %0d", out_ord_cnt, in_ord_cnt);

endmodule

bind ordered_mux ordered_mux_assertions protocol_checks (
    .clk         (clk),
    .rst         (rst),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .in_ord_cnt  (in_ord_cnt),
    .out_ord_cnt (out_ord_cnt)
);

// File: bench/ordered_mux_tb.sv
`timescale 1ns/1ps
`include "mux_defs.svh"

// Random orders and sources drive the DUT; a model of per-stream beat queues
// predicts every output beat.
module ordered_mux_tb
    import mux_pkg::*;
();

    localparam int N_DELIVERY     = 200;
    localparam int N_BACKPRESSURE = 200;
    localparam int N_STALL        = 100;
    localparam int N_COUNTERS     = 50;
    localparam int STALL_CYCLES   = 80;
    localparam int CYCLE_LIMIT    = 40 * (N_DELIVERY + N_BACKPRESSURE + N_STALL + N_COUNTERS);

    logic                  clk;
    logic                  rst;
    logic                  order_valid;
    logic                  order_ready;
    stream_id_t            order_data;
    logic [`MUX_NB_IN-1:0] in_valid;
    logic [`MUX_NB_IN-1:0] in_ready;
    beat_data_t            in_data [`MUX_NB_IN];
    logic                  out_valid;
    logic                  out_ready;
    beat_data_t            out_data;
    count_t                in_ord_cnt;
    count_t                out_ord_cnt;

    int         seed = 33;
    int         errors = 0;
    int         cycles = 0;
    int         orders_sent = 0;
    int         beats_out = 0;
    int         model_fifo = 0;
    logic [3:0] xfer_pipe = '0;
    string      test_name = "none";

    // Model state.
    stream_id_t ord_q [$];
    beat_data_t beat_q [`MUX_NB_IN][$];
    int         demand [`MUX_NB_IN];

    // Stimulus mode.
    bit         issue_orders = 1'b0;
    int         orders_to_issue = 0;
    int         bp_mode = 0;
    int         bp_run = 0;
    bit         stall_on = 1'b0;
    bit         stall_hit = 1'b0;
    stream_id_t stall_id = '0;

    // Offers still waiting for ready after the last edge.
    logic                  order_held = 1'b0;
    logic [`MUX_NB_IN-1:0] in_held = '0;

    ordered_mux ordered_mux_i (
        .clk         (clk),
        .rst         (rst),
        .order_valid (order_valid),
        .order_ready (order_ready),
        .order_data  (order_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .in_ord_cnt  (in_ord_cnt),
        .out_ord_cnt (out_ord_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog.
    initial begin
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        errors++;
    endtask

    // Handshakes are looked at on the falling edge, where all signals are
    // settled; a transfer seen here completes on the next rising edge.
    task automatic sample_handshakes();
        stream_id_t            sid;
        stream_id_t            exp_id;
        beat_data_t            exp_beat;
        logic                  in_xfer;
        logic [`MUX_NB_IN-1:0] stall_mask;
        in_xfer = 1'b0;
        // A granted beat is written into the output FIFO three edges after its transfer.
        if (xfer_pipe[3]) begin
            model_fifo++;
        end
        if (model_fifo > `MUX_OUT_DEPTH) begin
            report_error($sformatf("output FIFO overflow, %0d beats held", model_fifo));
        end
        if (in_ready != '0 && model_fifo > `MUX_ALMOST_FULL) begin
            report_error($sformatf("in_ready raised with %0d beats in the FIFO", model_fifo));
        end
        if (in_ord_cnt !== count_t'(orders_sent)) begin
            report_mismatch("in_ord_cnt", count_t'(orders_sent), in_ord_cnt);
        end
        if (stall_on) begin
            stall_mask = '0;
            stall_mask[stall_id] = 1'b1;
            if (in_ready[stall_id] && !in_valid[stall_id]) begin
                stall_hit = 1'b1;
            end
            if (stall_hit && in_ready != '0 && in_ready != stall_mask) begin
                report_error($sformatf("in_ready %b granted while stream %0d stalls",
                                       in_ready, stall_id));
            end
        end
        if (out_valid && out_ready) begin
            if (ord_q.size() == 0) begin
                report_error("output beat with no pending order entry");
            end else begin
                exp_id = ord_q.pop_front();
                if (beat_q[exp_id].size() == 0) begin
                    report_error($sformatf("output beat before stream %0d sent one", exp_id));
                end else begin
                    exp_beat = beat_q[exp_id].pop_front();
                    if (out_data !== exp_beat) begin
                        report_mismatch("out_data", exp_beat, out_data);
                    end
                end
            end
            beats_out++;
            model_fifo--;
        end
        if (order_valid && order_ready) begin
            ord_q.push_back(order_data);
            demand[order_data]++;
            orders_sent++;
            orders_to_issue--;
        end
        for (int s = 0; s < `MUX_NB_IN; s++) begin
            sid = stream_id_t'(s);
            if (in_valid[sid] && in_ready[sid]) begin
                beat_q[sid].push_back(in_data[sid]);
                demand[sid]--;
                in_xfer = 1'b1;
            end
        end
        xfer_pipe = {xfer_pipe[2:0], in_xfer};
        order_held = order_valid && !order_ready;
        in_held    = in_valid & ~in_ready;
    endtask

    // New values only where no transfer is pending.
    task automatic drive_inputs();
        int         r;
        stream_id_t sid;
        if (!order_held) begin
            r = $random(seed);
            order_valid = issue_orders && (orders_to_issue > 0) && ((r & 3) != 0);
            order_data  = stream_id_t'($random(seed));
        end
        // A source only offers a beat that an accepted order asks for.
        for (int s = 0; s < `MUX_NB_IN; s++) begin
            sid = stream_id_t'(s);
            if (!in_held[sid]) begin
                r = $random(seed);
                in_valid[sid] = (demand[sid] > 0) && ((r & 1) != 0)
                                && !(stall_on && sid == stall_id);
                in_data[sid]  = beat_data_t'($random(seed));
            end
        end
        if (bp_mode == 0) begin
            out_ready = 1'b1;
        end else begin
            if (bp_run == 0) begin
                r = $random(seed);
                out_ready = ((r & 7) >= 5);
                bp_run = 1 + ((r >> 8) & 31);
            end
            bp_run--;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        drive_inputs();
        sample_handshakes();
    endtask

    task automatic check_reset();
        test_name = "reset_state";
        if (out_valid !== 1'b0) begin
            report_mismatch("out_valid", 32'd0, 32'(out_valid));
        end
        if (in_ready !== '0) begin
            report_mismatch("in_ready", 32'd0, 32'(in_ready));
        end
        if (order_ready !== 1'b1) begin
            report_mismatch("order_ready", 32'd1, 32'(order_ready));
        end
        if (in_ord_cnt !== '0) begin
            report_mismatch("in_ord_cnt", 32'd0, in_ord_cnt);
        end
        if (out_ord_cnt !== '0) begin
            report_mismatch("out_ord_cnt", 32'd0, out_ord_cnt);
        end
        $display("reset_state: %0d errors", errors);
    endtask

    task automatic run_test(input string name, input int n, input int bp, input bit stall);
        int start_errors;
        int stall_cycles;
        test_name       = name;
        start_errors    = errors;
        stall_cycles    = 0;
        bp_mode         = bp;
        bp_run          = 0;
        orders_to_issue = n;
        issue_orders    = 1'b1;
        stall_on        = stall;
        stall_hit       = 1'b0;
        stall_id        = stream_id_t'($random(seed));
        while (orders_to_issue > 0 || stall_on) begin
            step_cycle();
            if (stall_on) begin
                stall_cycles++;
                if (stall_cycles >= STALL_CYCLES) begin
                    stall_on = 1'b0;
                end
            end
        end
        if (stall && !stall_hit) begin
            report_error($sformatf("stream %0d was never held waiting", stall_id));
        end
        // Drain with the sink always ready.
        issue_orders = 1'b0;
        bp_mode      = 0;
        while (beats_out < orders_sent) begin
            step_cycle();
        end
        step_cycle();
        if (out_valid !== 1'b0) begin
            report_mismatch("out_valid", 32'd0, 32'(out_valid));
        end
        if (out_ord_cnt !== count_t'(orders_sent)) begin
            report_mismatch("out_ord_cnt", count_t'(orders_sent), out_ord_cnt);
        end
        if (ord_q.size() != 0) begin
            report_error($sformatf("%0d order entries left unmatched", ord_q.size()));
        end
        $display("%s: %0d orders, %0d errors", name, n, errors - start_errors);
    endtask

    initial begin
        rst         = 1'b1;
        order_valid = 1'b0;
        order_data  = '0;
        in_valid    = '0;
        in_data     = '{default: '0};
        out_ready   = 1'b0;
        demand      = '{default: 0};
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset();
        run_test("ordered_delivery", N_DELIVERY, 0, 1'b0);
        run_test("back_pressure", N_BACKPRESSURE, 1, 1'b0);
        run_test("stream_stall", N_STALL, 0, 1'b1);
        run_test("counters", N_COUNTERS, 1, 1'b0);
        $display("Tests run: 5, orders: %0d, beats checked: %0d, errors: %0d",
                 orders_sent, beats_out, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/mux_pkg.sv
verilog/stream_fifo.sv
ordered_mux/order_sequencer.sv
ordered_mux/ordered_mux.sv
bench/ordered_mux_assertions.sv
bench/ordered_mux_tb.sv

// File: Makefile
# Verilator build and run of the ordered_mux testbench.

BIN  := obj_dir/Vordered_mux_tb
SRCS := common/mux_defs.svh common/mux_pkg.sv verilog/stream_fifo.sv \
        ordered_mux/order_sequencer.sv ordered_mux/ordered_mux.sv \
        bench/ordered_mux_assertions.sv bench/ordered_mux_tb.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) files.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module ordered_mux_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
